/* verilog.f */
src/bridge_pkg.sv
src/bridge_ctrl_if.sv
src/bridge_reset_seq.sv
src/cpu_index_tracker.sv
src/token_ctrl.sv
src/bridge_to_outside.sv
testbench/bridge_to_outside_assert.sv
testbench/tb_bridge_to_outside.sv

/* testbench/tb_bridge_to_outside.sv */
`timescale 1ns/1ps

module tb_bridge_to_outside import bridge_pkg::*; ();

  localparam int ADDR_W    = 64;
  localparam int HDR_SPACE = 16;
  localparam int NUM_ROWS  = 24;
  localparam int CLK_HALF  = 20;

  logic              clk;
  logic              ext_rst_b;
  core_state_e       state;
  cpu_index_t        ext_cpu_index;
  cpu_msg_e          ext_cpu_msg_in;
  logic              ext_next_cpu_q;
  logic [ADDR_W-1:0] addr_in;
  logic [DATA_W-1:0] data_in;
  logic              read_q;
  logic              write_q;
  logic              bus_busy_in;
  logic              rst;
  logic              ext_rst_e;
  logic              bus_busy_out;
  logic [ADDR_W-1:0] base_addr;
  logic [ADDR_W-1:0] base_addr_data;
  logic [1:0]        cpu_ind_rel;
  logic              disp_online;
  logic              next_state;
  logic              ext_next_cpu_e;
  logic              ext_dispatcher_q;
  cpu_msg_e          ext_cpu_msg;
  logic              ext_read_q;
  logic              ext_write_q;

  // one row of stimulus and expected outputs per clock
  string             row_name      [NUM_ROWS];
  core_state_e       row_state     [NUM_ROWS];
  // token, read_q, write_q, bus_busy_in
  logic [3:0]        row_ctl       [NUM_ROWS];
  logic [DATA_W-1:0] row_index     [NUM_ROWS];
  cpu_msg_e          row_msg_in    [NUM_ROWS];
  logic              row_zero_data [NUM_ROWS];
  cpu_msg_e          row_exp_msg   [NUM_ROWS];
  logic [1:0]        row_exp_rel   [NUM_ROWS];
  // rst ext_rst_e bus_busy_out, next_state ext_next_cpu_e disp_online,
  // ext_dispatcher_q ext_read_q ext_write_q
  logic [8:0]        row_exp_flags [NUM_ROWS];
  logic              row_chk_base  [NUM_ROWS];
  int                row_count;
  integer            seed;
  int                passed;
  int                failed;
  int                assert_fails;

  bridge_to_outside #(
    .ADDR_W              (ADDR_W),
    .THREAD_HEADER_SPACE (HDR_SPACE)
  ) bridge_to_outside_inst (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .state            (state),
    .ext_cpu_index    (ext_cpu_index),
    .ext_cpu_msg_in   (ext_cpu_msg_in),
    .ext_next_cpu_q   (ext_next_cpu_q),
    .addr_in          (addr_in),
    .data_in          (data_in),
    .read_q           (read_q),
    .write_q          (write_q),
    .bus_busy_in      (bus_busy_in),
    .rst              (rst),
    .ext_rst_e        (ext_rst_e),
    .bus_busy_out     (bus_busy_out),
    .base_addr        (base_addr),
    .base_addr_data   (base_addr_data),
    .cpu_ind_rel      (cpu_ind_rel),
    .disp_online      (disp_online),
    .next_state       (next_state),
    .ext_next_cpu_e   (ext_next_cpu_e),
    .ext_dispatcher_q (ext_dispatcher_q),
    .ext_cpu_msg      (ext_cpu_msg),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic add_row(input string name, input core_state_e st, input logic [3:0] ctl,
                         input logic [DATA_W-1:0] idx, input cpu_msg_e msg_in,
                         input logic zero_data, input cpu_msg_e exp_msg,
                         input logic [1:0] exp_rel, input logic [8:0] exp_flags,
                         input logic chk_base);
    row_name[row_count]      = name;
    row_state[row_count]     = st;
    row_ctl[row_count]       = ctl;
    row_index[row_count]     = idx;
    row_msg_in[row_count]    = msg_in;
    row_zero_data[row_count] = zero_data;
    row_exp_msg[row_count]   = exp_msg;
    row_exp_rel[row_count]   = exp_rel;
    row_exp_flags[row_count] = exp_flags;
    row_chk_base[row_count]  = chk_base;
    row_count++;
  endtask

  task automatic build_table();
    // start-up with index 5 captured in step 3
    add_row("seq_clear", IDLE_OTHER, 4'b0000, 32'h0000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b00, 9'b000_000_000, 1'b0);
    add_row("seq_check", IDLE_OTHER, 4'b0000, 32'h0000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b00, 9'b000_000_000, 1'b0);
    add_row("seq_capture", IDLE_OTHER, 4'b0000, 32'h0000_0005, MSG_NONE, 1'b0,
            MSG_RESET, 2'b00, 9'b000_000_000, 1'b0);
    add_row("seq_pulse", IDLE_OTHER, 4'b0000, 32'h0000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b00, 9'b111_000_000, 1'b0);
    add_row("seq_enable", IDLE_OTHER, 4'b0000, 32'h0000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b00, 9'b000_000_100, 1'b0);
    // relation with the bus busy so no grant happens
    add_row("rel_smaller", IDLE_OTHER, 4'b1001, 32'h0000_0003, MSG_NONE, 1'b0,
            MSG_NONE, 2'b01, 9'b000_000_100, 1'b0);
    add_row("rel_larger", IDLE_OTHER, 4'b1001, 32'h0000_0009, MSG_NONE, 1'b0,
            MSG_NONE, 2'b10, 9'b000_000_100, 1'b0);
    // same position but another active flag so the relation holds
    add_row("rel_flag_only", IDLE_OTHER, 4'b1001, 32'h8000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b10, 9'b000_000_100, 1'b0);
    add_row("rel_equal", IDLE_OTHER, 4'b1001, 32'h0000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b11, 9'b000_000_100, 1'b0);
    // thread start then START_BEGIN sets the active bit
    add_row("start_grant", WAIT_FOR_START, 4'b1000, 32'h0000_0005, MSG_NONE, 1'b0,
            MSG_START, 2'b11, 9'b000_111_100, 1'b1);
    add_row("start_release", START_BEGIN, 4'b0000, 32'h0000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b00, 9'b000_000_100, 1'b0);
    add_row("start_zero_data", WAIT_FOR_START, 4'b1000, 32'h8000_0005, MSG_NONE, 1'b1,
            MSG_START, 2'b11, 9'b000_111_100, 1'b1);
    add_row("start_release_2", IDLE_OTHER, 4'b0000, 32'h8000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b00, 9'b000_000_100, 1'b0);
    // request gating and token hand-off
    add_row("read_grant", READ_SRC0, 4'b1000, 32'h8000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b11, 9'b000_001_100, 1'b0);
    add_row("read_busy", READ_SRC0, 4'b0101, 32'h8000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b11, 9'b000_001_110, 1'b0);
    add_row("write_state_gate", WRITE_DST, 4'b0111, 32'h8000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b11, 9'b000_001_101, 1'b0);
    add_row("token_pass", READ_SRC0, 4'b0100, 32'h8000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b11, 9'b000_011_110, 1'b0);
    add_row("online_clear", READ_SRC0, 4'b0100, 32'h8000_0005, MSG_NONE, 1'b0,
            MSG_NONE, 2'b00, 9'b000_000_100, 1'b0);
    // own position goes 5 to 6 to 7 and back to 6
    add_row("other_start_a", IDLE_OTHER, 4'b0000, 32'h0000_0002, MSG_START, 1'b0,
            MSG_NONE, 2'b00, 9'b000_000_100, 1'b0);
    add_row("other_start_b", IDLE_OTHER, 4'b0000, 32'h0000_0004, MSG_START, 1'b0,
            MSG_NONE, 2'b00, 9'b000_000_100, 1'b0);
    add_row("other_end", IDLE_OTHER, 4'b0000, 32'h8000_0003, MSG_END, 1'b0,
            MSG_NONE, 2'b00, 9'b000_000_100, 1'b0);
    add_row("rel_tracked", IDLE_OTHER, 4'b1001, 32'h8000_0006, MSG_NONE, 1'b0,
            MSG_NONE, 2'b11, 9'b000_000_100, 1'b0);
    // thread finish
    add_row("finish_grant", FINISH_BEGIN, 4'b1000, 32'h8000_0006, MSG_NONE, 1'b0,
            MSG_END, 2'b11, 9'b000_111_100, 1'b0);
    add_row("finish_release", IDLE_OTHER, 4'b0000, 32'h8000_0006, MSG_NONE, 1'b0,
            MSG_NONE, 2'b00, 9'b000_000_100, 1'b0);
  endtask

  task automatic apply_inputs(input int r);
    state              = row_state[r];
    ext_next_cpu_q     = row_ctl[r][3];
    read_q             = row_ctl[r][2];
    write_q            = row_ctl[r][1];
    bus_busy_in        = row_ctl[r][0];
    ext_cpu_index.word = row_index[r];
    ext_cpu_msg_in     = row_msg_in[r];
    addr_in            = {$random(seed), $random(seed)};
    if (row_zero_data[r]) begin
      data_in = '0;
    end else begin
      data_in = $random(seed);
    end
  endtask

  task automatic compare_outputs(input int r);
    int                bad;
    logic [8:0]        flags;
    logic [ADDR_W-1:0] exp_base;
    logic [ADDR_W-1:0] exp_data;
    bad   = 0;
    flags = {rst, ext_rst_e, bus_busy_out, next_state, ext_next_cpu_e, disp_online,
             ext_dispatcher_q, ext_read_q, ext_write_q};
    // header space on top of the pointer or the address when data is zero
    exp_base = addr_in + HDR_SPACE;
    if (data_in == '0) begin
      exp_data = addr_in + HDR_SPACE;
    end else begin
      exp_data = {{(ADDR_W-DATA_W){1'b0}}, data_in} + HDR_SPACE;
    end
    if (ext_cpu_msg !== row_exp_msg[r]) begin
      $display("MISMATCH %s ext_cpu_msg expected %0d actual %0d",
               row_name[r], row_exp_msg[r], ext_cpu_msg);
      bad++;
    end
    if (cpu_ind_rel !== row_exp_rel[r]) begin
      $display("MISMATCH %s cpu_ind_rel expected %b actual %b",
               row_name[r], row_exp_rel[r], cpu_ind_rel);
      bad++;
    end
    if (flags !== row_exp_flags[r]) begin
      $display("MISMATCH %s flags expected %b actual %b",
               row_name[r], row_exp_flags[r], flags);
      bad++;
    end
    if (row_chk_base[r]) begin
      if (base_addr !== exp_base) begin
        $display("MISMATCH %s base_addr expected %h actual %h",
                 row_name[r], exp_base, base_addr);
        bad++;
      end
      if (base_addr_data !== exp_data) begin
        $display("MISMATCH %s base_addr_data expected %h actual %h",
                 row_name[r], exp_data, base_addr_data);
        bad++;
      end
    end
    if (bad == 0) begin
      passed++;
      $display("test %0d %s ok", r, row_name[r]);
    end else begin
      failed++;
      $display("test %0d %s failed with %0d wrong outputs", r, row_name[r], bad);
    end
  endtask

  initial begin
    seed               = 79672;
    row_count          = 0;
    passed             = 0;
    failed             = 0;
    assert_fails       = 0;
    ext_rst_b          = 1'b1;
    state              = IDLE_OTHER;
    ext_cpu_index.word = 32'h0000_0005;
    ext_cpu_msg_in     = MSG_NONE;
    ext_next_cpu_q     = 1'b0;
    addr_in            = '0;
    data_in            = '0;
    read_q             = 1'b0;
    write_q            = 1'b0;
    bus_busy_in        = 1'b0;
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    ext_rst_b = 1'b0;
    // inputs on the falling edge and outputs read one falling edge later
    for (int r = 0; r < row_count; r++) begin
      apply_inputs(r);
      @(posedge clk);
      @(negedge clk);
      compare_outputs(r);
    end
    assert_fails = bridge_to_outside_inst.bridge_assert_inst.failures;
    $display("tests %0d passed %0d failed %0d assertion failures %0d",
             row_count, passed, failed, assert_fails);
    if (failed == 0 && assert_fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog at four times the table plus margin
  initial begin
    #((NUM_ROWS + 20) * 2 * CLK_HALF * 4);
    $display("watchdog expired before all tests finished");
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* testbench/bridge_to_outside_assert.sv */
`timescale 1ns/1ps

module bridge_to_outside_assert import bridge_pkg::*; (
  input logic clk,
  input logic ext_rst_b,
  input logic rst,
  input logic ext_rst_e,
  input logic disp_online,
  input logic ext_next_cpu_e,
  input logic ext_read_q
);

  // count of failed assertions for the final verdict
  int failures = 0;

  // core reset is a single pulse
  rst_one_cycle: assert property (
    @(posedge clk) disable iff (ext_rst_b) rst |=> !rst
  ) else begin
    failures++;
    $error("rst stayed high for two cycles");
  end

  // reads reach the bus only with the token held
  read_needs_token: assert property (
    @(posedge clk) disable iff (ext_rst_b) ext_read_q |-> disp_online
  ) else begin
    failures++;
    $error("ext_read_q high without disp_online");
  end

  // token hand-off is a single pulse
  pass_one_cycle: assert property (
    @(posedge clk) disable iff (ext_rst_b) ext_next_cpu_e |=> !ext_next_cpu_e
  ) else begin
    failures++;
    $error("ext_next_cpu_e stayed high for two cycles");
  end

  // external reset only together with the core reset
  ext_rst_with_rst: assert property (
    @(posedge clk) disable iff (ext_rst_b) ext_rst_e |-> rst
  ) else begin
    failures++;
    $error("ext_rst_e high without rst");
  end

endmodule

bind bridge_to_outside bridge_to_outside_assert bridge_assert_inst (
  .clk            (clk),
  .ext_rst_b      (ext_rst_b),
  .rst            (rst),
  .ext_rst_e      (ext_rst_e),
  .disp_online    (disp_online),
  .ext_next_cpu_e (ext_next_cpu_e),
  .ext_read_q     (ext_read_q)
);

/* src/bridge_to_outside.sv */
`timescale 1ns/1ps

module bridge_to_outside import bridge_pkg::*; #(
  parameter int ADDR_W              = 64,
  parameter int THREAD_HEADER_SPACE = 16
) (
  input  logic              clk,
  input  logic              ext_rst_b,
  input  core_state_e       state,
  // token and message side
  input  cpu_index_t        ext_cpu_index,
  input  cpu_msg_e          ext_cpu_msg_in,
  input  logic              ext_next_cpu_q,
  // core side
  input  logic [ADDR_W-1:0] addr_in,
  input  logic [DATA_W-1:0] data_in,
  input  logic              read_q,
  input  logic              write_q,
  input  logic              bus_busy_in,
  // start-up outputs
  output logic              rst,
  output logic              ext_rst_e,
  output logic              bus_busy_out,
  // token controller outputs
  output logic [ADDR_W-1:0] base_addr,
  output logic [ADDR_W-1:0] base_addr_data,
  output logic [1:0]        cpu_ind_rel,
  output logic              disp_online,
  output logic              next_state,
  output logic              ext_next_cpu_e,
  output logic              ext_dispatcher_q,
  output cpu_msg_e          ext_cpu_msg,
  output logic              ext_read_q,
  output logic              ext_write_q
);

  // internal control bundle
  bridge_ctrl_if ctrl_if ();

  // start-up and restart steps
  bridge_reset_seq reset_seq_inst (
    .clk          (clk),
    .ext_rst_b    (ext_rst_b),
    .state        (state),
    .ctrl_if      (ctrl_if.seq),
    .rst          (rst),
    .ext_rst_e    (ext_rst_e),
    .bus_busy_out (bus_busy_out)
  );

  // own index word
  cpu_index_tracker index_tracker_inst (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .state          (state),
    .ext_cpu_index  (ext_cpu_index),
    .ext_cpu_msg_in (ext_cpu_msg_in),
    .ctrl_if        (ctrl_if.tracker)
  );

  // token, messages and request gates
  token_ctrl #(
    .ADDR_W              (ADDR_W),
    .THREAD_HEADER_SPACE (THREAD_HEADER_SPACE)
  ) token_ctrl_inst (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .state            (state),
    .addr_in          (addr_in),
    .data_in          (data_in),
    .read_q           (read_q),
    .write_q          (write_q),
    .bus_busy_in      (bus_busy_in),
    .ext_next_cpu_q   (ext_next_cpu_q),
    .ext_cpu_index    (ext_cpu_index),
    .ctrl_if          (ctrl_if.ctrl),
    .base_addr        (base_addr),
    .base_addr_data   (base_addr_data),
    .cpu_ind_rel      (cpu_ind_rel),
    .disp_online      (disp_online),
    .next_state       (next_state),
    .ext_next_cpu_e   (ext_next_cpu_e),
    .ext_dispatcher_q (ext_dispatcher_q),
    .ext_cpu_msg      (ext_cpu_msg),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q)
  );

endmodule

/* src/token_ctrl.sv */
`timescale 1ns/1ps

module token_ctrl import bridge_pkg::*; #(
  parameter int ADDR_W              = 64,
  parameter int THREAD_HEADER_SPACE = 16
) (
  input  logic              clk,
  input  logic              ext_rst_b,
  input  core_state_e       state,
  input  logic [ADDR_W-1:0] addr_in,
  input  logic [DATA_W-1:0] data_in,
  input  logic              read_q,
  input  logic              write_q,
  input  logic              bus_busy_in,
  input  logic              ext_next_cpu_q,
  input  cpu_index_t        ext_cpu_index,
  bridge_ctrl_if.ctrl       ctrl_if,
  output logic [ADDR_W-1:0] base_addr,
  output logic [ADDR_W-1:0] base_addr_data,
  output logic [1:0]        cpu_ind_rel,
  output logic              disp_online,
  output logic              next_state,
  output logic              ext_next_cpu_e,
  output logic              ext_dispatcher_q,
  output cpu_msg_e          ext_cpu_msg,
  output logic              ext_read_q,
  output logic              ext_write_q
);

  localparam logic [ADDR_W-1:0] HDR_SPACE = ADDR_W'(THREAD_HEADER_SPACE);

  cpu_index_t        own;
  logic              word_eq;
  logic              active;
  logic              grant;
  logic              pass_on;
  logic [ADDR_W-1:0] data_base;

  assign own     = ctrl_if.cpu_index;
  assign word_eq = (ext_cpu_index.word == own.word);
  // token logic sleeps while the start-up sequence runs
  assign active  = !ctrl_if.seq_running;

  // token is ours and the bus is free
  // no second grant while a pass pulse is out
  assign grant = active && ext_next_cpu_q && word_eq && !bus_busy_in && !ext_next_cpu_e;

  // a granted access goes out, hand the token on
  assign pass_on = active && disp_online && !bus_busy_in && !ext_next_cpu_e
                   && (read_q || write_q);

  // thread finished but someone else owns the bus
  assign ctrl_if.restart = active && !bus_busy_in && !grant && (state == FINISH_END);

  // zero data pointer falls back to the address
  assign data_base = (data_in == '0) ? addr_in : ADDR_W'(data_in);

  // bus requests only while holding the token
  assign ext_read_q  = (disp_online && is_read_state(state)) ? read_q : 1'b0;
  assign ext_write_q = (disp_online && is_write_state(state)) ? write_q : 1'b0;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cpu_ind_rel      <= 2'b00;
      disp_online      <= 1'b0;
      next_state       <= 1'b0;
      ext_next_cpu_e   <= 1'b0;
      ext_dispatcher_q <= 1'b0;
      ext_cpu_msg      <= MSG_NONE;
    end else begin
      // strobes, one cycle each
      next_state     <= 1'b0;
      ext_next_cpu_e <= 1'b0;
      ext_cpu_msg    <= MSG_NONE;

      // announce the reset while the index is captured
      if (ctrl_if.capture_index) begin
        ext_cpu_msg <= MSG_RESET;
      end
      if (ctrl_if.seq_clear) begin
        ext_dispatcher_q <= 1'b0;
        disp_online      <= 1'b0;
      end
      if (ctrl_if.seq_done) begin
        ext_dispatcher_q <= 1'b1;
      end

      if (active) begin
        // relation of the token index to ours, busy does not stall it
        if (ext_next_cpu_q) begin
          if (ext_cpu_index.fld.pos < own.fld.pos) begin
            cpu_ind_rel <= 2'b01;
          end else if (ext_cpu_index.fld.pos > own.fld.pos) begin
            cpu_ind_rel <= 2'b10;
          end else if (word_eq) begin
            cpu_ind_rel <= 2'b11;
          end
        end else if (ext_next_cpu_e) begin
          cpu_ind_rel <= 2'b00;
        end

        // token left us on the last edge
        if (ext_next_cpu_e) begin
          disp_online <= 1'b0;
        end

        if (pass_on) begin
          ext_next_cpu_e <= 1'b1;
        end

        if (grant) begin
          disp_online <= 1'b1;
          case (state)
            WAIT_FOR_START: begin
              ext_cpu_msg    <= MSG_START;
              base_addr      <= addr_in + HDR_SPACE;
              base_addr_data <= data_base + HDR_SPACE;
              ext_next_cpu_e <= 1'b1;
              next_state     <= 1'b1;
            end
            FINISH_BEGIN: begin
              ext_cpu_msg    <= MSG_END;
              ext_next_cpu_e <= 1'b1;
              next_state     <= 1'b1;
            end
            default: begin
              // bus access states keep the dispatcher asked
              if (is_read_state(state) || is_write_state(state)) begin
                ext_dispatcher_q <= 1'b1;
              end
            end
          endcase
        end
      end
    end
  end

endmodule

/* src/cpu_index_tracker.sv */
`timescale 1ns/1ps

module cpu_index_tracker import bridge_pkg::*; (
  input  logic              clk,
  input  logic              ext_rst_b,
  input  core_state_e       state,
  input  cpu_index_t        ext_cpu_index,
  input  cpu_msg_e          ext_cpu_msg_in,
  bridge_ctrl_if.tracker    ctrl_if
);

  // own index word
  cpu_index_t        idx;

  logic              same_word;
  logic              other_lt;
  logic              end_rule;
  logic              start_rule;
  logic [DATA_W-2:0] pos_inc;
  logic [DATA_W-2:0] pos_dec;

  assign ctrl_if.cpu_index = idx;

  assign same_word = (ext_cpu_index.word == idx.word);
  assign other_lt  = (ext_cpu_index.fld.pos < idx.fld.pos);
  assign pos_inc   = idx.fld.pos + 1'b1;
  assign pos_dec   = idx.fld.pos - 1'b1;

  // a lower active cpu finished its thread, we move down
  assign end_rule = ext_cpu_index.fld.active && idx.fld.active
                    && (ext_cpu_msg_in == MSG_END) && other_lt;

  // a non-active cpu started a thread
  assign start_rule = !ext_cpu_index.fld.active && (ext_cpu_msg_in == MSG_START);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      idx.word <= CPU_NONACTIVE;
    end else if (ctrl_if.capture_index) begin
      // index word from the bus during start-up
      idx <= ext_cpu_index;
    end else if (ctrl_if.restart) begin
      idx.word <= CPU_NONACTIVE;
    end else begin
      // thread begins, mark ourselves active
      if (state == START_BEGIN) begin
        idx.fld.active <= 1'b1;
      end

      // bookkeeping only for other cpus
      if (!same_word) begin
        if (end_rule) begin
          idx.fld.pos <= pos_dec;
        end else if (start_rule) begin
          // active ones shift up, idle ones shift down
          if (idx.fld.active) begin
            idx.fld.pos <= pos_inc;
          end else begin
            idx.fld.pos <= pos_dec;
          end
        end
      end
    end
  end

endmodule

/* src/bridge_reset_seq.sv */
`timescale 1ns/1ps

module bridge_reset_seq import bridge_pkg::*; (
  input  logic            clk,
  input  logic            ext_rst_b,
  input  core_state_e     state,
  bridge_ctrl_if.seq      ctrl_if,
  output logic            rst,
  output logic            ext_rst_e,
  output logic            bus_busy_out
);

  // step codes, idle parks the sequence
  localparam logic [2:0] STEP_IDLE    = 3'd0;
  localparam logic [2:0] STEP_CLEAR   = 3'd1;
  localparam logic [2:0] STEP_CHECK   = 3'd2;
  localparam logic [2:0] STEP_CAPTURE = 3'd3;
  localparam logic [2:0] STEP_PULSE   = 3'd4;
  localparam logic [2:0] STEP_ENABLE  = 3'd5;

  logic [2:0] step;
  // set when the index capture step ran
  logic       took_capture;

  // strobes straight off the step register
  assign ctrl_if.seq_clear     = (step == STEP_CLEAR);
  assign ctrl_if.capture_index = (step == STEP_CAPTURE);
  assign ctrl_if.seq_done      = (step == STEP_ENABLE);
  assign ctrl_if.seq_running   = (step != STEP_IDLE);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step         <= STEP_CLEAR;
      took_capture <= 1'b0;
      rst          <= 1'b0;
      ext_rst_e    <= 1'b0;
      bus_busy_out <= 1'b0;
    end else begin
      // reset pulses land one cycle after step 4
      rst          <= (step == STEP_PULSE);
      bus_busy_out <= (step == STEP_PULSE);
      // external reset only on a fresh start
      ext_rst_e    <= (step == STEP_PULSE) && took_capture;

      case (step)
        STEP_CLEAR: begin
          took_capture <= 1'b0;
          step         <= STEP_CHECK;
        end
        STEP_CHECK: begin
          // thread end skips the index capture
          if (state == FINISH_END) begin
            step <= STEP_PULSE;
          end else begin
            step <= STEP_CAPTURE;
          end
        end
        STEP_CAPTURE: begin
          took_capture <= 1'b1;
          step         <= STEP_PULSE;
        end
        STEP_PULSE: begin
          step <= STEP_ENABLE;
        end
        STEP_ENABLE: begin
          step <= STEP_IDLE;
        end
        default: begin
          // parked, wait for a restart from the token side
          if (ctrl_if.restart) begin
            step <= STEP_CLEAR;
          end
        end
      endcase
    end
  end

endmodule

/* src/bridge_ctrl_if.sv */
`timescale 1ns/1ps

// control lines shared by sequencer, index tracker and token controller
interface bridge_ctrl_if import bridge_pkg::*; ();

  // from the sequencer, decoded off its step register
  logic       seq_clear;
  logic       capture_index;
  logic       seq_done;
  logic       seq_running;
  // from the token controller
  logic       restart;
  // from the tracker
  cpu_index_t cpu_index;

  modport seq (
    output seq_clear, capture_index, seq_done, seq_running,
    input  restart
  );

  modport tracker (
    input  capture_index, restart,
    output cpu_index
  );

  modport ctrl (
    input  seq_clear, capture_index, seq_done, seq_running, cpu_index,
    output restart
  );

endinterface

/* src/bridge_pkg.sv */
package bridge_pkg;

  // word widths
  localparam int DATA_W    = 32;
  localparam int CPU_MSG_W = 8;

  // messages on the shared cpu message lines
  typedef enum logic [CPU_MSG_W-1:0] {
    MSG_NONE  = 0,
    MSG_RESET,
    MSG_START,
    MSG_END
  } cpu_msg_e;

  // core FSM state codes, as seen from the bridge
  typedef enum logic [5:0] {
    WAIT_FOR_START,
    START_BEGIN,
    START_READ_CMD,
    START_READ_CMD_P,
    READ_COND,
    READ_COND_P,
    READ_SRC1,
    READ_SRC1_P,
    READ_SRC0,
    READ_SRC0_P,
    READ_DST,
    READ_DST_P,
    WRITE_REG_IP,
    WRITE_DST,
    WRITE_DST_P,
    WRITE_SRC1,
    WRITE_SRC0,
    WRITE_COND,
    ALU_BEGIN,
    FINISH_BEGIN,
    FINISH_END,
    IDLE_OTHER
  } core_state_e;

  // index word split into active flag and position
  typedef struct packed {
    logic              active;
    logic [DATA_W-2:0] pos;
  } cpu_pos_t;

  // same 32 bits, raw or split
  typedef union packed {
    logic [DATA_W-1:0] word;
    cpu_pos_t          fld;
  } cpu_index_t;

  localparam logic [DATA_W-1:0] CPU_NONACTIVE = '0;
  localparam logic [DATA_W-1:0] CPU_ACTIVE    = {1'b1, {(DATA_W-1){1'b0}}};

  // core states that may issue a bus read
  function automatic logic is_read_state(core_state_e s);
    return s inside {START_READ_CMD, START_READ_CMD_P, READ_COND, READ_COND_P,
                     READ_SRC1, READ_SRC1_P, READ_SRC0, READ_SRC0_P,
                     READ_DST, READ_DST_P};
  endfunction

  // core states that may issue a bus write
  function automatic logic is_write_state(core_state_e s);
    return s inside {WRITE_REG_IP, WRITE_DST, WRITE_DST_P, WRITE_SRC1,
                     WRITE_SRC0, WRITE_COND};
  endfunction

endpackage
